// File: lsu_axi_pkg.sv
package lsu_axi_pkg;

  localparam int AXI_ID_W = 4;

  // Fixed single-beat transfer attributes
  localparam logic [7:0] AXI_LEN_ONE = 8'd0;
  localparam logic [2:0] AXI_SIZE_4B = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } funct3_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // One bus word seen as byte lanes or halfword lanes
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } data_word_u;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
    funct3_t     funct3;
  } lsu_req_t;

  typedef struct packed {
    logic       write;
    logic [31:0] addr;
    data_word_u data;
    logic [3:0] strb;
    funct3_t    funct3;
    logic       misalign;
  } lsu_op_t;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic        write;
  } lsu_rsp_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [31:0]         addr;
    logic [7:0]          len;
    logic [2:0]          size;
    logic [1:0]          burst;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    axi_resp_t           resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [31:0]         data;
    axi_resp_t           resp;
    logic                last;
  } axi_r_t;

endpackage

// File: lsu_req_stage.sv
`timescale 1ns/10ps

module lsu_req_stage
  import lsu_axi_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     req_valid,
  input  lsu_req_t req,
  output logic     req_ready,
  output logic     op_valid,
  output lsu_op_t  op,
  input  logic     op_ready
);

  lsu_op_t    op_d;
  logic [1:0] ofs;

  assign ofs = req.addr[1:0];

  // Accept when empty or when the held entry leaves this cycle
  assign req_ready = ~op_valid | op_ready;

  always_comb begin
    op_d        = '0;
    op_d.write  = req.write;
    op_d.addr   = req.addr;
    op_d.funct3 = req.funct3;
    case (req.funct3)
      F3_B, F3_BU: begin
        for (int i = 0; i < 4; i++) begin
          op_d.data.bytes[i] = req.data[7:0];
        end
        op_d.strb = 4'b0001 << ofs;
      end
      F3_H, F3_HU: begin
        for (int i = 0; i < 2; i++) begin
          op_d.data.halves[i] = req.data[15:0];
        end
        op_d.strb     = ofs[1] ? 4'b1100 : 4'b0011;
        op_d.misalign = ofs[0];
      end
      default: begin
        // Full word, any low address bit is an error
        op_d.data     = req.data;
        op_d.strb     = 4'b1111;
        op_d.misalign = |ofs;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      op_valid <= 1'b0;
    end else if (req_ready) begin
      op_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      op <= op_d;
    end
  end

endmodule

// File: lsu_axi_master.sv
`timescale 1ns/10ps

module lsu_axi_master
  import lsu_axi_pkg::*;
#(
  parameter logic [AXI_ID_W-1:0] MASTER_ID = '0
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     op_valid,
  input  lsu_op_t  op,
  output logic     op_ready,
  output axi_aw_t  aw,
  output logic     awvalid,
  input  logic     awready,
  output axi_w_t   w,
  output logic     wvalid,
  input  logic     wready,
  input  axi_b_t   b,
  input  logic     bvalid,
  output logic     bready,
  output axi_ar_t  ar,
  output logic     arvalid,
  input  logic     arready,
  input  axi_r_t   r,
  input  logic     rvalid,
  output logic     rready,
  output logic     res_valid,
  output lsu_rsp_t res,
  input  logic     res_ready,
  output lsu_op_t  res_op
);

  localparam int IDLE_BIT = 0;
  localparam int AR_BIT   = 1;
  localparam int R_BIT    = 2;
  localparam int AW_BIT   = 3;
  localparam int B_BIT    = 4;
  localparam int RES_BIT  = 5;

  typedef enum logic [5:0] {
    IDLE = 6'b000001,
    AR   = 6'b000010,
    R    = 6'b000100,
    AW   = 6'b001000,
    B    = 6'b010000,
    RES  = 6'b100000
  } state_t;

  state_t  state, state_d;
  lsu_op_t op_r;
  logic    aw_pend, w_pend;
  logic    op_hs, aw_hs, w_hs, ar_hs;

  assign op_hs = op_valid & op_ready;
  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign ar_hs = arvalid & arready;

  always_ff @(posedge clk) begin
    if (op_hs) begin
      op_r <= op;
    end
  end

  // AW and W may complete in different cycles
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else if (op_hs && op.write && !op.misalign) begin
      aw_pend <= 1'b1;
      w_pend  <= 1'b1;
    end else begin
      if (aw_hs) aw_pend <= 1'b0;
      if (w_hs) w_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  always_comb begin
    state_d = state;
    unique case (1'b1)
      state[IDLE_BIT]: begin
        if (op_valid) begin
          state_d = op.misalign ? RES : (op.write ? AW : AR);
        end
      end
      state[AR_BIT]: if (ar_hs) state_d = R;
      state[R_BIT]: if (rvalid && res_ready) state_d = IDLE;
      state[AW_BIT]: begin
        if ((!aw_pend || aw_hs) && (!w_pend || w_hs)) begin
          state_d = B;
        end
      end
      state[B_BIT]: if (bvalid && res_ready) state_d = IDLE;
      state[RES_BIT]: if (res_ready) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    aw.id    = MASTER_ID;
    aw.addr  = {op_r.addr[31:2], 2'b00};
    aw.len   = AXI_LEN_ONE;
    aw.size  = AXI_SIZE_4B;
    aw.burst = AXI_BURST_INCR;
    ar       = aw;
    w.data   = op_r.data;
    w.strb   = op_r.strb;
    w.last   = 1'b1;

    op_ready  = state[IDLE_BIT];
    arvalid   = state[AR_BIT];
    awvalid   = state[AW_BIT] & aw_pend;
    wvalid    = state[AW_BIT] & w_pend;
    rready    = state[R_BIT] & res_ready;
    bready    = state[B_BIT] & res_ready;
    res_valid = 1'b0;
    res       = '0;
    res.write = op_r.write;

    // R and B beats pass straight through to the response stage
    if (state[R_BIT]) begin
      res_valid = rvalid;
      res.data  = r.data;
      res.err   = (r.resp != RESP_OKAY);
    end else if (state[B_BIT]) begin
      res_valid = bvalid;
      res.err   = (b.resp != RESP_OKAY);
    end else if (state[RES_BIT]) begin
      res_valid = 1'b1;
      res.err   = 1'b1;
    end
  end

  assign res_op = op_r;

endmodule

// File: axi_sram_slave.sv
`timescale 1ns/10ps

module axi_sram_slave
  import lsu_axi_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic    clk,
  input  logic    rstn,
  input  axi_aw_t aw,
  input  logic    awvalid,
  output logic    awready,
  input  axi_w_t  w,
  input  logic    wvalid,
  output logic    wready,
  output axi_b_t  b,
  output logic    bvalid,
  input  logic    bready,
  input  axi_ar_t ar,
  input  logic    arvalid,
  output logic    arready,
  output axi_r_t  r,
  output logic    rvalid,
  input  logic    rready
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam logic [31:0] LIMIT = 32'(MEM_WORDS * 4);

  logic [31:0]      mem [MEM_WORDS];
  logic             wr_hs, rd_hs;
  logic             aw_ok, ar_ok;
  logic [IDX_W-1:0] aw_idx, ar_idx;

  assign aw_ok  = aw.addr < LIMIT;
  assign ar_ok  = ar.addr < LIMIT;
  assign aw_idx = aw.addr[IDX_W+1:2];
  assign ar_idx = ar.addr[IDX_W+1:2];

  // Address and data are taken together, one B outstanding at most
  assign awready = awvalid & wvalid & ~bvalid;
  assign wready  = awready;
  assign wr_hs   = awready;

  assign arready = ~rvalid;
  assign rd_hs   = arvalid & arready;

  always_ff @(posedge clk) begin
    if (wr_hs && aw_ok) begin
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bvalid <= 1'b0;
    end else if (wr_hs) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      b.id   <= aw.id;
      b.resp <= aw_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid <= 1'b0;
    end else if (rd_hs) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Out of range reads return zero
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      r.id   <= ar.id;
      r.data <= ar_ok ? mem[ar_idx] : '0;
      r.resp <= ar_ok ? RESP_OKAY : RESP_SLVERR;
      r.last <= 1'b1;
    end
  end

endmodule

// File: lsu_resp_stage.sv
`timescale 1ns/10ps

module lsu_resp_stage
  import lsu_axi_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     res_valid,
  input  lsu_rsp_t res,
  input  lsu_op_t  res_op,
  output logic     res_ready,
  output logic     rsp_valid,
  output lsu_rsp_t rsp,
  input  logic     rsp_ready
);

  data_word_u  word;
  logic [1:0]  ofs;
  logic [7:0]  lb;
  logic [15:0] lh;
  lsu_rsp_t    rsp_d;

  assign res_ready = ~rsp_valid | rsp_ready;

  always_comb begin
    word  = res.data;
    ofs   = res_op.addr[1:0];
    lb    = word.bytes[ofs];
    lh    = word.halves[ofs[1]];
    rsp_d = res;
    if (res.write || res.err) begin
      rsp_d.data = '0;
    end else begin
      case (res_op.funct3)
        F3_B:    rsp_d.data = {{24{lb[7]}}, lb};
        F3_BU:   rsp_d.data = {24'b0, lb};
        F3_H:    rsp_d.data = {{16{lh[15]}}, lh};
        F3_HU:   rsp_d.data = {16'b0, lh};
        default: rsp_d.data = word;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else if (res_ready) begin
      rsp_valid <= res_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid && res_ready) begin
      rsp <= rsp_d;
    end
  end

endmodule

// File: lsu_axi_top.sv
`timescale 1ns/10ps

module lsu_axi_top
  import lsu_axi_pkg::*;
#(
  parameter int                  MEM_WORDS = 256,
  parameter logic [AXI_ID_W-1:0] MASTER_ID = '0
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     req_valid,
  input  lsu_req_t req,
  output logic     req_ready,
  output logic     rsp_valid,
  output lsu_rsp_t rsp,
  input  logic     rsp_ready
);

  logic     op_valid, op_ready;
  lsu_op_t  op;
  logic     res_valid, res_ready;
  lsu_rsp_t res;
  lsu_op_t  res_op;

  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  axi_ar_t ar;
  axi_r_t  r;
  logic    awvalid, awready, wvalid, wready, bvalid, bready;
  logic    arvalid, arready, rvalid, rready;

  lsu_req_stage i_lsu_req_stage (
    .clk, .rstn, .req_valid, .req, .req_ready, .op_valid, .op, .op_ready
  );

  lsu_axi_master #(.MASTER_ID(MASTER_ID)) i_lsu_axi_master (
    .clk, .rstn, .op_valid, .op, .op_ready,
    .aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
    .ar, .arvalid, .arready, .r, .rvalid, .rready,
    .res_valid, .res, .res_ready, .res_op
  );

  axi_sram_slave #(.MEM_WORDS(MEM_WORDS)) i_axi_sram_slave (
    .clk, .rstn,
    .aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
    .ar, .arvalid, .arready, .r, .rvalid, .rready
  );

  lsu_resp_stage i_lsu_resp_stage (
    .clk, .rstn, .res_valid, .res, .res_op, .res_ready, .rsp_valid, .rsp, .rsp_ready
  );

endmodule

// File: tb_lsu_axi.sv
`timescale 1ns/10ps

module tb_lsu_axi
  import lsu_axi_pkg::*;
();

  localparam int MEM_WORDS = 64;
  localparam int MAX_ROWS  = 64;

  logic     clk;
  logic     rstn;
  logic     req_valid;
  lsu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  lsu_rsp_t rsp;
  logic     rsp_ready;

  lsu_req_t    row_req [MAX_ROWS];
  logic [31:0] row_exp [MAX_ROWS];
  logic        row_err [MAX_ROWS];
  logic [31:0] shadow  [MEM_WORDS];
  logic [31:0] lcg_state = 32'd39;
  int          n_rows = 0;
  int          got = 0;
  int          cycles = 0;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;

  lsu_axi_top #(.MEM_WORDS(MEM_WORDS)) i_lsu_axi_top (
    .clk, .rstn, .req_valid, .req, .req_ready, .rsp_valid, .rsp, .rsp_ready
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_store(input logic [31:0] addr, input logic [31:0] data,
                           input funct3_t f3, input logic exp_err);
    lsu_req_t q;
    q.write = 1'b1;
    q.addr = addr;
    q.data = data;
    q.funct3 = f3;
    row_req[n_rows] = q;
    row_exp[n_rows] = 32'h0;
    row_err[n_rows] = exp_err;
    n_rows++;
  endtask

  task automatic add_load(input logic [31:0] addr, input funct3_t f3,
                          input logic [31:0] exp_data, input logic exp_err);
    lsu_req_t q;
    q.write = 1'b0;
    q.addr = addr;
    q.data = 32'h0;
    q.funct3 = f3;
    row_req[n_rows] = q;
    row_exp[n_rows] = exp_data;
    row_err[n_rows] = exp_err;
    n_rows++;
  endtask

  task automatic build_table();
    logic [31:0] s;
    logic [31:0] rnd [4];
    s = 32'd39;
    // Word store and load back
    add_store(32'h00, 32'h1234_5678, F3_W, 1'b0);
    add_load(32'h00, F3_W, 32'h1234_5678, 1'b0);
    // Byte and halfword merges
    add_store(32'h04, 32'hAABB_CCDD, F3_W, 1'b0);
    add_store(32'h04, 32'h0000_0011, F3_B, 1'b0);
    add_load(32'h04, F3_W, 32'hAABB_CC11, 1'b0);
    add_store(32'h05, 32'h0000_0022, F3_B, 1'b0);
    add_store(32'h06, 32'h0000_0033, F3_B, 1'b0);
    add_store(32'h07, 32'h0000_0044, F3_B, 1'b0);
    add_load(32'h04, F3_W, 32'h4433_2211, 1'b0);
    add_store(32'h08, 32'h0123_4567, F3_W, 1'b0);
    add_store(32'h08, 32'h0000_BEEF, F3_H, 1'b0);
    add_load(32'h08, F3_W, 32'h0123_BEEF, 1'b0);
    add_store(32'h0A, 32'h0000_CAFE, F3_H, 1'b0);
    add_load(32'h08, F3_W, 32'hCAFE_BEEF, 1'b0);
    // Sign and zero extension
    add_store(32'h0C, 32'hF0E1_8283, F3_W, 1'b0);
    add_load(32'h0C, F3_B, 32'hFFFF_FF83, 1'b0);
    add_load(32'h0D, F3_BU, 32'h0000_0082, 1'b0);
    add_load(32'h0E, F3_B, 32'hFFFF_FFE1, 1'b0);
    add_load(32'h0F, F3_BU, 32'h0000_00F0, 1'b0);
    add_load(32'h0C, F3_H, 32'hFFFF_8283, 1'b0);
    add_load(32'h0C, F3_HU, 32'h0000_8283, 1'b0);
    add_load(32'h0E, F3_H, 32'hFFFF_F0E1, 1'b0);
    add_load(32'h0E, F3_HU, 32'h0000_F0E1, 1'b0);
    add_load(32'h07, F3_B, 32'h0000_0044, 1'b0);
    // Out of range accesses that would alias words 0 and 1
    add_store(32'h100, 32'hDEAD_BEEF, F3_W, 1'b1);
    add_load(32'h100, F3_W, 32'h0, 1'b1);
    add_store(32'h104, 32'h0000_0055, F3_B, 1'b1);
    add_load(32'h00, F3_W, 32'h1234_5678, 1'b0);
    // Misaligned
    add_load(32'h0D, F3_H, 32'h0, 1'b1);
    add_store(32'h02, 32'hFFFF_FFFF, F3_W, 1'b1);
    add_store(32'h05, 32'h0000_9999, F3_H, 1'b1);
    add_load(32'h00, F3_W, 32'h1234_5678, 1'b0);
    add_load(32'h04, F3_W, 32'h4433_2211, 1'b0);
    // Back to back random words
    for (int j = 0; j < 4; j++) begin
      s = lcg_next(s);
      rnd[j] = s;
      add_store(32'h10 + 4 * j, rnd[j], F3_W, 1'b0);
    end
    for (int j = 0; j < 4; j++) begin
      add_load(32'h10 + 4 * j, F3_W, rnd[j], 1'b0);
    end
  endtask

  // Reference memory model built from the access rules
  task automatic shadow_model(input int i, output logic [31:0] data, output logic err);
    lsu_req_t    q;
    logic [1:0]  ofs;
    int          idx;
    logic [31:0] word;
    logic [7:0]  bt;
    logic [15:0] hf;
    q = row_req[i];
    ofs = q.addr[1:0];
    idx = int'(q.addr[31:2]);
    data = 32'h0;
    err = 1'b0;
    if ((q.funct3 == F3_H || q.funct3 == F3_HU) && ofs[0]) err = 1'b1;
    if (q.funct3 == F3_W && ofs != 2'b00) err = 1'b1;
    if (q.addr >= 32'(MEM_WORDS * 4)) err = 1'b1;
    if (err) return;
    if (q.write) begin
      case (q.funct3)
        F3_B, F3_BU: shadow[idx][8*ofs +: 8] = q.data[7:0];
        F3_H, F3_HU: shadow[idx][8*ofs +: 16] = q.data[15:0];
        default:     shadow[idx] = q.data;
      endcase
    end else begin
      word = shadow[idx];
      case (q.funct3)
        F3_B, F3_BU: begin
          bt = word[8*ofs +: 8];
          data = (q.funct3 == F3_B) ? {{24{bt[7]}}, bt} : {24'h0, bt};
        end
        F3_H, F3_HU: begin
          hf = word[8*ofs +: 16];
          data = (q.funct3 == F3_H) ? {{16{hf[15]}}, hf} : {16'h0, hf};
        end
        default: data = word;
      endcase
    end
  endtask

  task automatic cross_check_table();
    logic [31:0] d;
    logic        e;
    for (int i = 0; i < n_rows; i++) begin
      shadow_model(i, d, e);
      assert (d === row_exp[i]) else begin
        $display("mismatch at %0t: row %0d exp_data table %h shadow %h",
                 $time, i, row_exp[i], d);
        errors++;
      end
      assert (e === row_err[i]) else begin
        $display("mismatch at %0t: row %0d exp_err table %b shadow %b",
                 $time, i, row_err[i], e);
        errors++;
      end
    end
  endtask

  task automatic check_response(input int k);
    int bad;
    bad = 0;
    assert (rsp.data === row_exp[k]) else begin
      $display("mismatch at %0t: rsp.data row %0d expected %h got %h",
               $time, k, row_exp[k], rsp.data);
      bad++;
    end
    assert (rsp.err === row_err[k]) else begin
      $display("mismatch at %0t: rsp.err row %0d expected %b got %b",
               $time, k, row_err[k], rsp.err);
      bad++;
    end
    assert (rsp.write === row_req[k].write) else begin
      $display("mismatch at %0t: rsp.write row %0d expected %b got %b",
               $time, k, row_req[k].write, rsp.write);
      bad++;
    end
    if (bad == 0) begin
      passed++;
      $display("row %0d addr %h funct3 %0d write %b ok", k, row_req[k].addr,
               row_req[k].funct3, row_req[k].write);
    end else begin
      failed++;
      errors += bad;
      $display("row %0d addr %h failed with %0d wrong fields", k, row_req[k].addr, bad);
    end
  endtask

  // Random back-pressure on the response
  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rsp_ready <= 1'b0;
    end else begin
      lcg_state <= lcg_next(lcg_state);
      rsp_ready <= (lcg_state[23:22] != 2'b00);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 10 + 30 * n_rows) begin
      $display("Run timed out after %0d cycles with %0d of %0d responses",
               cycles, got, n_rows);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b0;
    foreach (shadow[k]) shadow[k] = 'x;
    build_table();
    cross_check_table();
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < n_rows; i++) begin
      req_valid <= 1'b1;
      req <= row_req[i];
      @(negedge clk);
      while (!req_ready) @(negedge clk);
      @(posedge clk);
    end
    req_valid <= 1'b0;
  end

  initial begin
    int extra;
    extra = 0;
    wait (rstn === 1'b1);
    while (got < n_rows) begin
      @(negedge clk);
      if (rsp_valid && rsp_ready) begin
        check_response(got);
        got++;
      end
    end
    // Nothing may follow the last response
    repeat (20) begin
      @(negedge clk);
      if (rsp_valid) extra++;
    end
    assert (extra == 0) else begin
      $display("An extra response appeared after the last row");
      errors++;
    end
    $display("Rows %0d, passed %0d, failed %0d, errors %0d", n_rows, passed, failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: lsu_axi.f
lsu_axi_pkg.sv
lsu_req_stage.sv
lsu_axi_master.sv
axi_sram_slave.sv
lsu_resp_stage.sv
lsu_axi_top.sv
tb_lsu_axi.sv
